// File: bpu_pkg.sv
// Branch prediction package
// Shared sizes, table geometry, opcode and counter state encodings

package bpu_pkg;

  // Fetch packet geometry
  localparam int SLOTS      = 4;
  localparam int SLOT_IDX_W = 2;
  localparam int INSTR_W    = 32;
  localparam int PKT_W      = SLOTS * INSTR_W;

  // Branch history table, indexed by pc[7:2]
  localparam int BHT_ENTRIES = 64;
  localparam int BHT_IDX_W   = 6;

  // Branch target buffer, indexed by pc[6:2], tagged with pc[31:7]
  localparam int BTB_ENTRIES = 32;
  localparam int BTB_IDX_W   = 5;
  localparam int BTB_TAG_W   = 25;

  // Major opcodes the decoder cares about
  typedef enum logic [6:0] {
    OP_OTHER  = 7'b0000000,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  // Two bit counter states, taken when the upper bit is clear
  typedef enum logic [1:0] {
    ST  = 2'b00,
    WT  = 2'b01,
    WNT = 2'b10,
    SNT = 2'b11
  } pred_state_e;

  // One bit per instruction slot
  typedef logic [SLOTS-1:0] slot_mask_t;

endpackage

// File: bpu_if.sv
// Fetch packet and branch resolve interfaces
// Shared between the decode, prediction tables and redirect logic

`timescale 1ns/10ps

interface fetch_pkt_if;

  bpu_pkg::slot_mask_t        valid;
  logic [bpu_pkg::PKT_W-1:0] instr;
  // Halfword fetch address, slot base is derived by each consumer
  logic [31:1]                pc;

  modport producer (
    output valid,
    output instr,
    output pc
  );

  modport consumer (
    input valid,
    input instr,
    input pc
  );

endinterface

interface resolve_if;

  logic        valid;
  logic [31:1] pc;
  logic        taken;
  logic [31:1] target;

  // Execute stage report, no back-pressure
  modport trainer (
    input valid,
    input pc,
    input taken,
    input target
  );

endinterface

// File: jal_decode.sv
// Slot decoder for the branch predictor
// Flags JAL and conditional branches and computes JAL targets

`timescale 1ns/10ps

module jal_decode (
  fetch_pkt_if.consumer              fetch,
  output bpu_pkg::slot_mask_t        jal,
  output bpu_pkg::slot_mask_t        branch,
  output logic [bpu_pkg::SLOTS-1:0][31:1] jal_target
);

  for (genvar i = 0; i < bpu_pkg::SLOTS; i++) begin : g_slot
    logic [bpu_pkg::INSTR_W-1:0] word;
    logic [31:1]                 slot_pc;
    logic [31:1]                 imm;
    bpu_pkg::opcode_e            op;

    assign word = fetch.instr[i*bpu_pkg::INSTR_W +: bpu_pkg::INSTR_W];

    // Packet base plus four bytes per slot
    assign slot_pc = {fetch.pc[31:4], bpu_pkg::SLOT_IDX_W'(i), 1'b0};

    always_comb begin
      case (word[6:0])
        bpu_pkg::OP_JAL:    op = bpu_pkg::OP_JAL;
        bpu_pkg::OP_BRANCH: op = bpu_pkg::OP_BRANCH;
        default:            op = bpu_pkg::OP_OTHER;
      endcase
    end

    // J-type immediate, imm[20|10:1|11|19:12], sign extended
    assign imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21]};

    assign jal[i]        = fetch.valid[i] && (op == bpu_pkg::OP_JAL);
    assign branch[i]     = fetch.valid[i] && (op == bpu_pkg::OP_BRANCH);
    assign jal_target[i] = slot_pc + imm;
  end

endmodule

// File: pred_counter.sv
// Two bit saturating branch counter
// Steps toward ST on taken and toward SNT on not taken

`timescale 1ns/10ps

module pred_counter (
  input  logic                 update,
  input  logic                 taken,
  input  bpu_pkg::pred_state_e state_in,
  output bpu_pkg::pred_state_e state_out,
  output logic                 take
);

  always_comb begin
    state_out = state_in;
    if (update) begin
      case (state_in)
        bpu_pkg::ST:  state_out = taken ? bpu_pkg::ST  : bpu_pkg::WT;
        bpu_pkg::WT:  state_out = taken ? bpu_pkg::ST  : bpu_pkg::WNT;
        bpu_pkg::WNT: state_out = taken ? bpu_pkg::WT  : bpu_pkg::SNT;
        bpu_pkg::SNT: state_out = taken ? bpu_pkg::WNT : bpu_pkg::SNT;
        default:      state_out = state_in;
      endcase
    end
  end

  // Taken side of the table has the upper bit clear
  assign take = ~state_in[1];

endmodule

// File: bht.sv
// Branch history table of 2-bit counters
// Four combinational slot lookups and one training port

`timescale 1ns/10ps

module bht (
  input  logic                clk,
  input  logic                rst_n,
  fetch_pkt_if.consumer       fetch,
  resolve_if.trainer          res,
  output bpu_pkg::slot_mask_t pred_taken
);

  bpu_pkg::pred_state_e           cnt_q [bpu_pkg::BHT_ENTRIES];
  bpu_pkg::pred_state_e           cnt_wr;
  logic [bpu_pkg::BHT_IDX_W-1:0]  res_idx;

  assign res_idx = res.pc[7:2];

  // Training path, holds the entry when no resolve is present
  pred_counter wr_ctr_i (
    .update   (res.valid),
    .taken    (res.taken),
    .state_in (cnt_q[res_idx]),
    .state_out(cnt_wr),
    .take     ()
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int e = 0; e < bpu_pkg::BHT_ENTRIES; e++) begin
        cnt_q[e] <= bpu_pkg::WNT;
      end
    end else begin
      cnt_q[res_idx] <= cnt_wr;
    end
  end

  // Lookup per slot
  for (genvar i = 0; i < bpu_pkg::SLOTS; i++) begin : g_rd
    logic [bpu_pkg::BHT_IDX_W-1:0] rd_idx;

    assign rd_idx = {fetch.pc[7:4], bpu_pkg::SLOT_IDX_W'(i)};

    pred_counter rd_ctr_i (
      .update   (1'b0),
      .taken    (1'b0),
      .state_in (cnt_q[rd_idx]),
      .state_out(),
      .take     (pred_taken[i])
    );
  end

endmodule

// File: btb.sv
// Direct-mapped branch target buffer
// Filled by taken resolves, looked up for every fetch slot

`timescale 1ns/10ps

module btb (
  input  logic                              clk,
  input  logic                              rst_n,
  fetch_pkt_if.consumer                     fetch,
  resolve_if.trainer                        res,
  output bpu_pkg::slot_mask_t               hit,
  output logic [bpu_pkg::SLOTS-1:0][31:1]   target
);

  logic                          valid_q [bpu_pkg::BTB_ENTRIES];
  logic [bpu_pkg::BTB_TAG_W-1:0] tag_q   [bpu_pkg::BTB_ENTRIES];
  logic [31:1]                   tgt_q   [bpu_pkg::BTB_ENTRIES];

  logic [bpu_pkg::BTB_IDX_W-1:0] wr_idx;
  logic [bpu_pkg::BTB_TAG_W-1:0] wr_tag;
  logic                          wr_en;

  assign wr_idx = res.pc[6:2];
  assign wr_tag = res.pc[31:7];
  // Not-taken resolves never allocate
  assign wr_en  = res.valid && res.taken;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int e = 0; e < bpu_pkg::BTB_ENTRIES; e++) begin
        valid_q[e] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target payload
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx] <= wr_tag;
      tgt_q[wr_idx] <= res.target;
    end
  end

  for (genvar i = 0; i < bpu_pkg::SLOTS; i++) begin : g_rd
    logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0] rd_tag;

    assign rd_idx = {fetch.pc[6:4], bpu_pkg::SLOT_IDX_W'(i)};
    assign rd_tag = fetch.pc[31:7];

    assign hit[i]    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target[i] = tgt_q[rd_idx];
  end

  // Taken resolve is visible to lookups after the edge that writes it
  wr_visible_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |=> valid_q[$past(wr_idx)] &&
              (tag_q[$past(wr_idx)] == $past(wr_tag)) &&
              (tgt_q[$past(wr_idx)] == $past(res.target))
  ) else $error("btb: taken resolve was not written to its entry");

endmodule

// File: jal_redirect.sv
// Redirect select for a fetch packet
// Earliest taken slot wins, plus registered write mask and JAL flag

`timescale 1ns/10ps

module jal_redirect (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            flush,
  fetch_pkt_if.consumer                   fetch,
  input  bpu_pkg::slot_mask_t             jal,
  input  bpu_pkg::slot_mask_t             branch,
  input  logic [bpu_pkg::SLOTS-1:0][31:1] jal_target,
  input  bpu_pkg::slot_mask_t             pred_taken,
  input  bpu_pkg::slot_mask_t             hit,
  input  logic [bpu_pkg::SLOTS-1:0][31:1] btb_target,
  output logic                            redir_en,
  output logic [31:1]                     redir_target,
  output bpu_pkg::slot_mask_t             slot_wren,
  output logic                            jal_en_q
);

  bpu_pkg::slot_mask_t            redir_mask;
  logic [bpu_pkg::SLOT_IDX_W-1:0] win_idx;
  bpu_pkg::slot_mask_t            wren_d;
  logic                           jal_win;

  // Branches need both a taken prediction and a known target
  assign redir_mask = jal | (branch & pred_taken & hit);
  assign redir_en   = |redir_mask;

  // Scan from the top so the lowest set slot is left in win_idx
  always_comb begin
    win_idx = '0;
    for (int i = bpu_pkg::SLOTS - 1; i >= 0; i--) begin
      if (redir_mask[i]) begin
        win_idx = bpu_pkg::SLOT_IDX_W'(i);
      end
    end
  end

  assign jal_win = redir_en && jal[win_idx];

  always_comb begin
    if (!redir_en) begin
      // Sequential fetch, next 16 byte packet
      redir_target = {fetch.pc[31:4] + 28'd1, 3'b000};
    end else if (jal_win) begin
      redir_target = jal_target[win_idx];
    end else begin
      redir_target = btb_target[win_idx];
    end
  end

  always_comb begin
    wren_d = fetch.valid;
    if (redir_en) begin
      for (int i = 0; i < bpu_pkg::SLOTS; i++) begin
        wren_d[i] = (i <= int'(win_idx));
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_wren <= '0;
      jal_en_q  <= 1'b0;
    end else if (flush) begin
      slot_wren <= '0;
      jal_en_q  <= 1'b0;
    end else begin
      slot_wren <= wren_d;
      jal_en_q  <= jal_win;
    end
  end

  // Mask after a redirect is 0001, 0011, 0111 or 1111
  wren_run_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (redir_en && !flush) |=> slot_wren[0] && (((slot_wren + 1'b1) & slot_wren) == '0)
  ) else $error("jal_redirect: slot_wren %b is not a run from slot 0", slot_wren);

endmodule

// File: ifu_bpu.sv
// Branch prediction unit of the instruction fetch stage
// Connects fetch and resolve ports to decode, BHT, BTB and redirect

`timescale 1ns/10ps

module ifu_bpu (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  logic [3:0]          fetch_valid,
  input  logic [127:0]        fetch_instr,
  input  logic [31:1]         fetch_pc,
  input  logic                res_valid,
  input  logic [31:1]         res_pc,
  input  logic                res_taken,
  input  logic [31:1]         res_target,
  output logic                redir_en,
  output logic [31:1]         redir_target,
  output logic [3:0]          slot_wren,
  output logic                jal_en_q
);

  fetch_pkt_if fetch_i ();
  resolve_if   res_i ();

  bpu_pkg::slot_mask_t             jal;
  bpu_pkg::slot_mask_t             branch;
  bpu_pkg::slot_mask_t             pred_taken;
  bpu_pkg::slot_mask_t             hit;
  logic [bpu_pkg::SLOTS-1:0][31:1] jal_target;
  logic [bpu_pkg::SLOTS-1:0][31:1] btb_target;

  assign fetch_i.valid = fetch_valid;
  assign fetch_i.instr = fetch_instr;
  assign fetch_i.pc    = fetch_pc;

  assign res_i.valid  = res_valid;
  assign res_i.pc     = res_pc;
  assign res_i.taken  = res_taken;
  assign res_i.target = res_target;

  jal_decode dec_i (
    .fetch     (fetch_i),
    .jal       (jal),
    .branch    (branch),
    .jal_target(jal_target)
  );

  bht bht_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch     (fetch_i),
    .res       (res_i),
    .pred_taken(pred_taken)
  );

  btb btb_i (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (fetch_i),
    .res   (res_i),
    .hit   (hit),
    .target(btb_target)
  );

  jal_redirect redir_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .fetch       (fetch_i),
    .jal         (jal),
    .branch      (branch),
    .jal_target  (jal_target),
    .pred_taken  (pred_taken),
    .hit         (hit),
    .btb_target  (btb_target),
    .redir_en    (redir_en),
    .redir_target(redir_target),
    .slot_wren   (slot_wren),
    .jal_en_q    (jal_en_q)
  );

endmodule

// File: tb_ifu_bpu.sv
// Testbench for the fetch branch prediction unit
// Reference model of counters and BTB, checked by concurrent assertions

`timescale 1ns/10ps

module tb_ifu_bpu;

  typedef enum int {FILL, JUMP, BRANCH} slot_kind_e;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         flush;
  logic [3:0]   fetch_valid;
  logic [127:0] fetch_instr;
  logic [31:1]  fetch_pc;
  logic         res_valid;
  logic [31:1]  res_pc;
  logic         res_taken;
  logic [31:1]  res_target;
  logic         redir_en;
  logic [31:1]  redir_target;
  logic [3:0]   slot_wren;
  logic         jal_en_q;

  // Expected values, valid while chk_now or chk_q is set
  logic         chk_now = 1'b0;
  logic         chk_q = 1'b0;
  logic         exp_en;
  logic [31:1]  exp_tgt;
  logic [3:0]   exp_wren;
  logic [3:0]   exp_wren_q;
  logic         exp_jal;
  logic         exp_jal_q;

  // Reference tables, counter 0 is strongly taken and 3 strongly not taken
  int           ref_cnt [bpu_pkg::BHT_ENTRIES];
  logic         ref_bv  [bpu_pkg::BTB_ENTRIES];
  logic [24:0]  ref_tag [bpu_pkg::BTB_ENTRIES];
  logic [31:0]  ref_tgt [bpu_pkg::BTB_ENTRIES];

  slot_kind_e   pk_kind [4];
  int           pk_off  [4];
  string        cur_test;
  int           test_errs;
  int           err_cnt = 0;
  int           pass_cnt = 0;
  int           fail_cnt = 0;

  ifu_bpu dut_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    chk_q      <= chk_now;
    exp_wren_q <= exp_wren;
    exp_jal_q  <= exp_jal;
  end

  task automatic note_error();
    err_cnt++;
    test_errs++;
  endtask

  redir_en_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_now |-> redir_en == exp_en)
  else begin
    $display("** Error [%s] redir_en expected %0b actual %0b",
             cur_test, $sampled(exp_en), $sampled(redir_en));
    note_error();
  end

  redir_tgt_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_now |-> redir_target == exp_tgt)
  else begin
    $display("** Error [%s] redir_target expected %h actual %h",
             cur_test, $sampled(exp_tgt), $sampled(redir_target));
    note_error();
  end

  wren_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_q |-> slot_wren == exp_wren_q)
  else begin
    $display("** Error [%s] slot_wren expected %b actual %b",
             cur_test, $sampled(exp_wren_q), $sampled(slot_wren));
    note_error();
  end

  jal_q_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_q |-> jal_en_q == exp_jal_q)
  else begin
    $display("** Error [%s] jal_en_q expected %0b actual %0b",
             cur_test, $sampled(exp_jal_q), $sampled(jal_en_q));
    note_error();
  end

  // RV32 encodings, filler keeps the OP-IMM opcode
  function automatic logic [31:0] slot_word(input slot_kind_e kind, input int off);
    logic [31:0] w;
    logic [20:0] o;
    o = off[20:0];
    case (kind)
      JUMP:    w = {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
      BRANCH:  w = {7'd0, 5'd2, 5'd1, 3'b001, 5'd0, 7'b1100011};
      default: begin
        w = $urandom();
        w[6:0] = 7'b0010011;
      end
    endcase
    return w;
  endfunction

  task automatic clear_slots();
    for (int i = 0; i < 4; i++) begin
      pk_kind[i] = FILL;
      pk_off[i]  = 0;
    end
  endtask

  task automatic set_slot(input int i, input slot_kind_e kind, input int off);
    pk_kind[i] = kind;
    pk_off[i]  = off;
  endtask

  task automatic send_packet(input logic [31:0] addr, input logic [3:0] vld,
                             input logic fl);
    logic [127:0] pkt;
    logic [31:0]  base;
    logic [31:0]  slot_a;
    logic [31:0]  tgt;
    logic         is_jal;
    int           win;
    base   = {addr[31:4], 4'h0};
    tgt    = base + 32'd16;
    win    = -1;
    is_jal = 1'b0;
    for (int i = 0; i < 4; i++) begin
      pkt[i*32 +: 32] = slot_word(pk_kind[i], pk_off[i]);
      slot_a = base + 32'(4 * i);
      if (win < 0 && vld[i] && pk_kind[i] == JUMP) begin
        win    = i;
        is_jal = 1'b1;
        tgt    = slot_a + 32'(pk_off[i]);
      end else if (win < 0 && vld[i] && pk_kind[i] == BRANCH &&
                   ref_cnt[slot_a[7:2]] < 2 && ref_bv[slot_a[6:2]] &&
                   ref_tag[slot_a[6:2]] == slot_a[31:7]) begin
        win = i;
        tgt = ref_tgt[slot_a[6:2]];
      end
    end
    @(posedge clk);
    fetch_pc    <= addr[31:1];
    fetch_valid <= vld;
    fetch_instr <= pkt;
    flush       <= fl;
    res_valid   <= 1'b0;
    chk_now     <= 1'b1;
    exp_en      <= (win >= 0);
    exp_tgt     <= tgt[31:1];
    exp_wren    <= fl ? 4'b0000 : ((win >= 0) ? 4'((1 << (win + 1)) - 1) : vld);
    exp_jal     <= !fl && is_jal;
  endtask

  task automatic train(input logic [31:0] addr, input logic tk, input logic [31:0] tgt);
    @(posedge clk);
    res_valid   <= 1'b1;
    res_pc      <= addr[31:1];
    res_taken   <= tk;
    res_target  <= tgt[31:1];
    fetch_valid <= 4'b0000;
    flush       <= 1'b0;
    chk_now     <= 1'b0;
    if (tk && ref_cnt[addr[7:2]] > 0) begin
      ref_cnt[addr[7:2]]--;
    end else if (!tk && ref_cnt[addr[7:2]] < 3) begin
      ref_cnt[addr[7:2]]++;
    end
    if (tk) begin
      ref_bv[addr[6:2]]  = 1'b1;
      ref_tag[addr[6:2]] = addr[31:7];
      ref_tgt[addr[6:2]] = tgt;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      fetch_valid <= 4'b0000;
      res_valid   <= 1'b0;
      flush       <= 1'b0;
      chk_now     <= 1'b0;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
    clear_slots();
  endtask

  // Three idle edges let the delayed checks of the last packet complete
  task automatic end_test();
    idle(3);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("PASS  %s", cur_test);
    end else begin
      fail_cnt++;
      $display("FAIL  %s (%0d mismatches)", cur_test, test_errs);
    end
  endtask

  initial begin : watchdog
    int unsigned test_cycles;
    // Reset plus the cycles of the six tests below
    test_cycles = 16 + 50;
    #(test_cycles * 40 * 2);
    $display("Watchdog expired before the test sequence finished");
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(72322));
    rst_n = 1'b0;
    flush = 1'b0;
    fetch_valid = '0;
    fetch_instr = '0;
    fetch_pc = '0;
    res_valid = 1'b0;
    res_pc = '0;
    res_taken = 1'b0;
    res_target = '0;
    for (int e = 0; e < bpu_pkg::BHT_ENTRIES; e++) ref_cnt[e] = 2;
    for (int e = 0; e < bpu_pkg::BTB_ENTRIES; e++) ref_bv[e] = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("plain_packet");
    send_packet(32'h0000_1000, 4'b1111, 1'b0);
    send_packet(32'h0000_1234, 4'b0101, 1'b0);
    end_test();

    // Slot 0 JAL is masked off, slot 2 wins over slot 3
    begin_test("jal_priority");
    set_slot(0, JUMP, 64);
    set_slot(2, JUMP, 256);
    set_slot(3, JUMP, -64);
    send_packet(32'h0000_4006, 4'b1110, 1'b0);
    clear_slots();
    set_slot(3, JUMP, -2048);
    send_packet(32'h0000_4ff0, 4'b1111, 1'b0);
    end_test();

    begin_test("branch_train");
    set_slot(2, BRANCH, 0);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2008, 1'b1, 32'h0000_3000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    end_test();

    begin_test("counter_saturation");
    set_slot(2, BRANCH, 0);
    train(32'h0000_2008, 1'b1, 32'h0000_3000);
    train(32'h0000_2008, 1'b1, 32'h0000_3000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2008, 1'b0, 32'h0000_0000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2008, 1'b0, 32'h0000_0000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2008, 1'b0, 32'h0000_0000);
    train(32'h0000_2008, 1'b0, 32'h0000_0000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2008, 1'b1, 32'h0000_3000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2008, 1'b1, 32'h0000_3000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    end_test();

    // 0x2088 shares the BTB index of 0x2008 with another tag
    begin_test("btb_tag_alias");
    set_slot(2, BRANCH, 0);
    train(32'h0000_2088, 1'b0, 32'h0000_5000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2088, 1'b1, 32'h0000_5000);
    send_packet(32'h0000_2000, 4'b1111, 1'b0);
    train(32'h0000_2088, 1'b1, 32'h0000_5000);
    send_packet(32'h0000_2080, 4'b1111, 1'b0);
    end_test();

    begin_test("flush_clears");
    set_slot(1, JUMP, 512);
    send_packet(32'h0000_6000, 4'b1111, 1'b1);
    send_packet(32'h0000_6000, 4'b1111, 1'b0);
    end_test();

    $display("Tests: %0d passed, %0d failed, %0d mismatches", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
bpu_pkg.sv
bpu_if.sv
jal_decode.sv
pred_counter.sv
bht.sv
btb.sv
jal_redirect.sv
ifu_bpu.sv
tb_ifu_bpu.sv

// File: Bender.yml
package:
  name: ifu_bpu

sources:
  - bpu_pkg.sv
  - bpu_if.sv
  - jal_decode.sv
  - pred_counter.sv
  - bht.sv
  - btb.sv
  - jal_redirect.sv
  - ifu_bpu.sv
  - target: simulation
    files:
      - tb_ifu_bpu.sv
